// File: hw/merge_pkg.sv
package merge_pkg;

    // ######################################
    // widths
    // ######################################
    localparam int DATA_W     = 32;     // stream word
    localparam int FIFO_DEPTH = 5;      // per channel, deliberately not 2**n
    localparam int CNT_W      = 16;     // transfer counters
    localparam int APB_AW     = 8;
    localparam int APB_DW     = 32;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [APB_AW-1:0] paddr_t;
    typedef logic [APB_DW-1:0] pdata_t;

    // ######################################
    // register map
    // ######################################
    localparam paddr_t REG_CTRL   = 8'h00;  // chaos enables + clear
    localparam paddr_t REG_STATUS = 8'h04;  // live fifo flags, read only
    localparam paddr_t REG_CNT_A  = 8'h08;  // read only
    localparam paddr_t REG_CNT_B  = 8'h0C;  // read only

    // CTRL bit positions
    localparam int CTRL_CHAOS_A = 0;
    localparam int CTRL_CHAOS_B = 1;
    localparam int CTRL_CLEAR   = 2;        // self clearing

    // STATUS bit positions
    localparam int STAT_EMPTY_A = 0;
    localparam int STAT_FULL_A  = 1;
    localparam int STAT_EMPTY_B = 2;
    localparam int STAT_FULL_B  = 3;

endpackage

// File: hw/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter int DW    = 32,   // word width
    parameter int DEPTH = 4     // any depth, not only 2**n
) (
    input  logic          clk,
    input  logic          nreset,
    input  logic          clear,      // sync flush of both pointers
    input  logic          chaosmode,  // pseudo random full when set
    // write side
    input  logic          wr_en,
    input  logic [DW-1:0] wr_din,
    output logic          wr_full,
    // read side
    input  logic          rd_en,      // caller guarantees not empty
    output logic [DW-1:0] rd_dout,    // combinational head
    output logic          rd_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);  // last slot index

    // pointers carry a wrap flag in the msb
    logic [AW:0]   wr_addr;
    logic [AW:0]   rd_addr;
    logic [AW:0]   wr_addr_nxt;
    logic [AW:0]   rd_addr_nxt;
    logic          fifo_write;
    logic          fifo_read;
    logic [6:0]    lfsr;
    logic [DW-1:0] mem [DEPTH];

    // ######################################
    // flags
    // ######################################

    // full when only the wrap flag differs
    assign wr_full  = (chaosmode & lfsr[0]) |
                      ({~wr_addr[AW], wr_addr[AW-1:0]} == rd_addr);
    assign rd_empty = (wr_addr == rd_addr);

    assign fifo_write = wr_en & ~wr_full;   // writes while full are dropped
    assign fifo_read  = rd_en;              // no second empty check here

    // ######################################
    // pointers, wrap at DEPTH-1
    // ######################################

    // flip wrap flag when leaving the last slot
    assign wr_addr_nxt = (wr_addr[AW-1:0] == LAST) ? {~wr_addr[AW], {AW{1'b0}}}
                                                   : wr_addr + 1'b1;
    assign rd_addr_nxt = (rd_addr[AW-1:0] == LAST) ? {~rd_addr[AW], {AW{1'b0}}}
                                                   : rd_addr + 1'b1;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_addr <= '0;
            rd_addr <= '0;
        end else if (clear) begin
            wr_addr <= '0;      // flush, contents left as is
            rd_addr <= '0;
        end else begin
            if (fifo_write)
                wr_addr <= wr_addr_nxt;
            if (fifo_read)
                rd_addr <= rd_addr_nxt;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (fifo_write)
            mem[wr_addr[AW-1:0]] <= wr_din;
    end

    assign rd_dout = mem[rd_addr[AW-1:0]];  // oldest word

    // ######################################
    // chaos lfsr, x^7 + x^6 + 1
    // ######################################
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset)
            lfsr <= 7'h5b;      // any nonzero seed
        else
            lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
    end

    // pops come from the combiner, must never hit an empty fifo
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!nreset)
        rd_en |-> !rd_empty);

    // slot index stays inside the ram
    a_addr_range: assert property (@(posedge clk) disable iff (!nreset)
        (int'(wr_addr[AW-1:0]) < DEPTH) && (int'(rd_addr[AW-1:0]) < DEPTH));

    // real full and empty exclude each other
    a_full_empty: assert property (@(posedge clk) disable iff (!nreset)
        (rd_empty && wr_full) |-> (chaosmode && lfsr[0]));

endmodule

// File: hw/rr_merge.sv
`timescale 1ns/10ps

module rr_merge (
    input  logic                clk,
    input  logic                nreset,
    // fifo a head
    input  logic                a_empty,
    input  merge_pkg::data_t    a_head,
    output logic                pop_a,
    // fifo b head
    input  logic                b_empty,
    input  merge_pkg::data_t    b_head,
    output logic                pop_b,
    // merged stream
    output logic                out_valid,
    output merge_pkg::data_t    out_data,
    output logic                out_src,    // 0 = a, 1 = b
    input  logic                out_ready
);

    logic prio;         // 1 prefers b on a tie
    logic grant_b;
    logic xfer;

    // ######################################
    // grant
    // ######################################

    // b wins if it is the only one, or on a tie with prio set
    assign grant_b   = ~b_empty & (a_empty | prio);
    assign out_valid = ~a_empty | ~b_empty;
    assign out_src   = grant_b;
    assign out_data  = grant_b ? b_head : a_head;

    assign xfer  = out_valid & out_ready;
    assign pop_a = xfer & ~grant_b;     // a non-empty whenever granted
    assign pop_b = xfer & grant_b;

    // ######################################
    // priority bit
    // ######################################
    // after a transfer point at the other channel.
    // during a stall lock onto the current grantee so a word arriving
    // on the other side cannot steal the grant and change out_data
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset)
            prio <= 1'b0;
        else if (out_valid)
            prio <= out_ready ? ~grant_b : grant_b;
    end

    // one fifo popped per transfer
    a_one_pop: assert property (@(posedge clk) disable iff (!nreset)
        !(pop_a && pop_b));

    // stalled output holds its word and source unless a clear empties it
    a_stall_stable: assert property (@(posedge clk) disable iff (!nreset)
        (out_valid && !out_ready) |=>
            (!out_valid || ($stable(out_data) && $stable(out_src))));

endmodule

// File: hw/apb_regs.sv
`timescale 1ns/10ps

module apb_regs (
    input  logic                clk,
    input  logic                nreset,
    // apb slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  merge_pkg::paddr_t   paddr,
    input  merge_pkg::pdata_t   pwdata,
    output merge_pkg::pdata_t   prdata,
    output logic                pready,
    output logic                pslverr,
    // datapath events
    input  logic                pop_a,
    input  logic                pop_b,
    input  logic                a_empty,
    input  logic                a_full,
    input  logic                b_empty,
    input  logic                b_full,
    // control out
    output logic                chaos_a,
    output logic                chaos_b,
    output logic                clear       // one cycle pulse
);

    import merge_pkg::*;

    logic   access;     // apb access phase
    logic   sel_ctrl;
    logic   mapped;
    logic   wr_ctrl;
    pdata_t ctrl_rd;
    pdata_t status;
    cnt_t   cnt_a;
    cnt_t   cnt_b;

    // ######################################
    // decode
    // ######################################
    assign access   = psel & penable;
    assign sel_ctrl = (paddr == REG_CTRL);
    assign mapped   = sel_ctrl | (paddr == REG_STATUS) |
                      (paddr == REG_CNT_A) | (paddr == REG_CNT_B);
    assign wr_ctrl  = access & pwrite & sel_ctrl;  // only writable reg

    assign pready  = 1'b1;     // zero wait states
    assign pslverr = access & (~mapped | (pwrite & ~sel_ctrl));

    // ######################################
    // control
    // ######################################
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            chaos_a <= 1'b0;
            chaos_b <= 1'b0;
            clear   <= 1'b0;
        end else begin
            clear <= wr_ctrl & pwdata[CTRL_CLEAR];  // drops next cycle
            if (wr_ctrl) begin
                chaos_a <= pwdata[CTRL_CHAOS_A];
                chaos_b <= pwdata[CTRL_CHAOS_B];
            end
        end
    end

    // transfer counters, wrap at CNT_W
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            cnt_a <= '0;
            cnt_b <= '0;
        end else if (clear) begin
            cnt_a <= '0;
            cnt_b <= '0;
        end else begin
            if (pop_a)
                cnt_a <= cnt_a + 1'b1;
            if (pop_b)
                cnt_b <= cnt_b + 1'b1;
        end
    end

    // ######################################
    // read mux
    // ######################################
    always_comb begin
        ctrl_rd               = '0;     // clear bit reads 0
        ctrl_rd[CTRL_CHAOS_A] = chaos_a;
        ctrl_rd[CTRL_CHAOS_B] = chaos_b;
        status                = '0;     // live flags
        status[STAT_EMPTY_A]  = a_empty;
        status[STAT_FULL_A]   = a_full;
        status[STAT_EMPTY_B]  = b_empty;
        status[STAT_FULL_B]   = b_full;
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_CTRL:   prdata = ctrl_rd;
                REG_STATUS: prdata = status;
                REG_CNT_A:  prdata = pdata_t'(cnt_a);
                REG_CNT_B:  prdata = pdata_t'(cnt_b);
                default:    prdata = '0;        // unmapped
            endcase
        end
    end

    // apb needs two cycles per access, so no back to back clear
    a_clear_pulse: assert property (@(posedge clk) disable iff (!nreset)
        clear |=> !clear);

endmodule

// File: hw/merge_top.sv
`timescale 1ns/10ps

module merge_top (
    input  logic                clk,
    input  logic                nreset,
    // stream a in
    input  logic                a_valid,
    input  merge_pkg::data_t    a_data,
    output logic                a_ready,
    // stream b in
    input  logic                b_valid,
    input  merge_pkg::data_t    b_data,
    output logic                b_ready,
    // merged out
    output logic                out_valid,
    output merge_pkg::data_t    out_data,
    output logic                out_src,
    input  logic                out_ready,
    // apb
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  merge_pkg::paddr_t   paddr,
    input  merge_pkg::pdata_t   pwdata,
    output merge_pkg::pdata_t   prdata,
    output logic                pready,
    output logic                pslverr
);

    import merge_pkg::*;

    logic  a_full, a_empty, pop_a;
    logic  b_full, b_empty, pop_b;
    data_t a_head;
    data_t b_head;
    logic  chaos_a, chaos_b;
    logic  clear;               // from CTRL, one cycle

    assign a_ready = ~a_full;   // includes chaos full
    assign b_ready = ~b_full;

    // ######################################
    // channel fifos
    // ######################################
    sync_fifo #(.DW(DATA_W), .DEPTH(FIFO_DEPTH)) u_fifo_a (
        .clk(clk), .nreset(nreset), .clear(clear), .chaosmode(chaos_a),
        .wr_en(a_valid), .wr_din(a_data), .wr_full(a_full),
        .rd_en(pop_a), .rd_dout(a_head), .rd_empty(a_empty)
    );

    sync_fifo #(.DW(DATA_W), .DEPTH(FIFO_DEPTH)) u_fifo_b (
        .clk(clk), .nreset(nreset), .clear(clear), .chaosmode(chaos_b),
        .wr_en(b_valid), .wr_din(b_data), .wr_full(b_full),
        .rd_en(pop_b), .rd_dout(b_head), .rd_empty(b_empty)
    );

    // round robin onto one stream
    rr_merge u_rr_merge (
        .clk(clk), .nreset(nreset),
        .a_empty(a_empty), .a_head(a_head), .pop_a(pop_a),
        .b_empty(b_empty), .b_head(b_head), .pop_b(pop_b),
        .out_valid(out_valid), .out_data(out_data), .out_src(out_src),
        .out_ready(out_ready)
    );

    // control and status
    apb_regs u_apb_regs (
        .clk(clk), .nreset(nreset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .pop_a(pop_a), .pop_b(pop_b),
        .a_empty(a_empty), .a_full(a_full), .b_empty(b_empty), .b_full(b_full),
        .chaos_a(chaos_a), .chaos_b(chaos_b), .clear(clear)
    );

endmodule

// File: verification/tb_merge_top.sv
`timescale 1ns/10ps

module tb_merge_top;

    import merge_pkg::*;

    localparam int TIMEOUT = 100;   // cycles per wait loop

    logic   clk, nreset;
    logic   a_valid, a_ready, b_valid, b_ready;
    data_t  a_data, b_data, out_data;
    logic   out_valid, out_ready, out_src;
    logic   psel, penable, pwrite, pready, pslverr;
    paddr_t paddr;
    pdata_t pwdata, prdata;

    int     seed = 68243;
    data_t  q_a[$];                 // accepted and not yet sent
    data_t  q_b[$];
    int     size_a, size_b;         // queue mirrors that change on edges only
    data_t  head_a, head_b;
    cnt_t   xfer_a, xfer_b;         // expected CNT_A / CNT_B
    logic   chaos_m_a, chaos_m_b;   // chaos enables as last written
    logic   clear_due, tie_prev, src_prev;
    int     chaos_hits_a, chaos_hits_b, tie_pairs;
    pdata_t rd_data;
    logic   rd_err;
    data_t  exp_data;
    logic   tie_now;

    merge_top uut (.*);

    assign exp_data = out_src ? head_b : head_a;
    assign tie_now  = (size_a != 0) && (size_b != 0);   // both channels pending

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_reg(input string name, input pdata_t exp, input pdata_t act);
        assert (act === exp) else
            report_failure($sformatf("Mismatch at %0t: %s expected %h got %h",
                                     $time, name, exp, act));
    endtask

    // ######################################
    // scoreboard
    // ######################################
    always @(posedge clk or negedge nreset) begin
        logic both;
        if (!nreset) begin
            q_a.delete();
            q_b.delete();
            xfer_a <= '0;
            xfer_b <= '0;
            {chaos_m_a, chaos_m_b, clear_due, tie_prev, src_prev} <= '0;
            chaos_hits_a = 0;
            chaos_hits_b = 0;
            tie_pairs    = 0;
        end else if (clear_due) begin
            q_a.delete();           // fifos flush on this edge too
            q_b.delete();
            xfer_a    <= '0;
            xfer_b    <= '0;
            tie_prev  <= 1'b0;
            clear_due <= 1'b0;
        end else begin
            both = (q_a.size() != 0) && (q_b.size() != 0);
            // ready low with room left means chaos
            if (!a_ready && q_a.size() < FIFO_DEPTH)
                chaos_hits_a++;
            if (!b_ready && q_b.size() < FIFO_DEPTH)
                chaos_hits_b++;
            if (out_valid && out_ready) begin
                if (out_src) begin
                    if (q_b.size() != 0)
                        void'(q_b.pop_front());
                    xfer_b <= xfer_b + 1'b1;    // wraps like the dut counter
                end else begin
                    if (q_a.size() != 0)
                        void'(q_a.pop_front());
                    xfer_a <= xfer_a + 1'b1;
                end
                if (both && tie_prev)
                    tie_pairs++;
                tie_prev <= both;
                src_prev <= out_src;
            end
            if (a_valid && a_ready)
                q_a.push_back(a_data);
            if (b_valid && b_ready)
                q_b.push_back(b_data);
            // CTRL write lands on the access edge
            if (psel && penable && pwrite && paddr == REG_CTRL) begin
                chaos_m_a <= pwdata[CTRL_CHAOS_A];
                chaos_m_b <= pwdata[CTRL_CHAOS_B];
                clear_due <= pwdata[CTRL_CLEAR];    // flush one edge later
            end
        end
        size_a <= q_a.size();
        size_b <= q_b.size();
        head_a <= (q_a.size() != 0) ? q_a[0] : '0;
        head_b <= (q_b.size() != 0) ? q_b[0] : '0;
    end

    // ######################################
    // checks
    // ######################################
    a_out_data: assert property (@(posedge clk) disable iff (!nreset)
        (out_valid && out_ready) |->
            ((out_src ? size_b : size_a) != 0 && out_data == exp_data))
        else report_failure($sformatf("Mismatch at %0t: out_data expected %h got %h",
                                      $time, $sampled(exp_data), $sampled(out_data)));

    a_out_valid: assert property (@(posedge clk) disable iff (!nreset)
        out_valid == (size_a != 0 || size_b != 0))
        else report_failure($sformatf("Mismatch at %0t: out_valid expected %b got %b",
                                      $time,
                                      $sampled(size_a) != 0 || $sampled(size_b) != 0,
                                      $sampled(out_valid)));

    // two ties in a row go to different channels
    a_round_robin: assert property (@(posedge clk) disable iff (!nreset)
        (out_valid && out_ready && tie_now && tie_prev) |-> (out_src != src_prev))
        else report_failure($sformatf("Mismatch at %0t: out_src expected %b got %b",
                                      $time, !$sampled(src_prev), $sampled(out_src)));

    a_stall_hold: assert property (@(posedge clk) disable iff (!nreset)
        (out_valid && !out_ready) |=>
            (!out_valid || ($stable(out_data) && $stable(out_src))))
        else report_failure("output word or source changed while stalled");

    a_ready_a: assert property (@(posedge clk) disable iff (!nreset)
        (size_a >= FIFO_DEPTH) ? !a_ready : (chaos_m_a || a_ready))
        else report_failure($sformatf("Mismatch at %0t: a_ready expected %b got %b",
                                      $time, $sampled(size_a) < FIFO_DEPTH,
                                      $sampled(a_ready)));

    a_ready_b: assert property (@(posedge clk) disable iff (!nreset)
        (size_b >= FIFO_DEPTH) ? !b_ready : (chaos_m_b || b_ready))
        else report_failure($sformatf("Mismatch at %0t: b_ready expected %b got %b",
                                      $time, $sampled(size_b) < FIFO_DEPTH,
                                      $sampled(b_ready)));

    // ######################################
    // stimulus tasks
    // ######################################
    task automatic apb_access(input logic wr, input paddr_t addr, input pdata_t wdata);
        int n;
        @(posedge clk);
        psel    <= 1'b1;            // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;            // access phase
        n = 0;
        @(negedge clk);
        while (!pready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!pready)
            report_failure("apb slave never raised pready");
        rd_data = prdata;           // mid cycle and stable
        rd_err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic drive(input logic av, input logic bv, input logic ordy);
        @(posedge clk);
        a_valid   <= av;
        b_valid   <= bv;
        out_ready <= ordy;
        a_data    <= $random(seed);
        b_data    <= $random(seed);
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] rnd;
        repeat (cycles) begin
            rnd = $random(seed);
            drive(rnd[0], rnd[1], rnd[2] | rnd[3]);    // ready 3 of 4
        end
    endtask

    // stop the inputs and wait for both queues to empty
    task automatic drain(input logic ordy);
        int n;
        drive(1'b0, 1'b0, ordy);
        n = 0;
        @(negedge clk);
        while ((size_a != 0 || size_b != 0 || out_valid) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (size_a == 0 && size_b == 0 && !out_valid) else
            report_failure("queues or out_valid not empty after waiting for drain");
    endtask

    // push one channel into a stalled output until its ready drops
    task automatic fill_channel(input logic ch);
        int n;
        n = 0;
        do begin
            drive(!ch, ch, 1'b0);
            @(negedge clk);
            n++;
        end while ((ch ? b_ready : a_ready) && n < TIMEOUT);
        check_reg(ch ? "b queue depth" : "a queue depth", FIFO_DEPTH, ch ? size_b : size_a);
    endtask

    // ######################################
    // test sequence
    // ######################################
    initial begin
        nreset    = 1'b0;
        a_valid   = 1'b0;
        a_data    = '0;
        b_valid   = 1'b0;
        b_data    = '0;
        out_ready = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (2) @(posedge clk);
        nreset <= 1'b1;

        random_traffic(400);
        drain(1'b1);

        fill_channel(1'b0);
        fill_channel(1'b1);
        repeat (20)
            drive(1'b1, 1'b1, 1'b1);    // both pending with output open
        assert (tie_pairs > 0) else
            report_failure("no back to back transfers with both channels pending");
        drain(1'b1);

        apb_access(1'b0, REG_STATUS, '0);
        check_reg("STATUS", (1 << STAT_EMPTY_A) | (1 << STAT_EMPTY_B), rd_data);
        apb_access(1'b0, REG_CNT_A, '0);
        check_reg("CNT_A", pdata_t'(xfer_a), rd_data);
        apb_access(1'b0, REG_CNT_B, '0);
        check_reg("CNT_B", pdata_t'(xfer_b), rd_data);
        apb_access(1'b0, 8'h10, '0);    // unmapped
        check_reg("pslverr", 1, rd_err);
        check_reg("prdata", 0, rd_data);

        apb_access(1'b1, REG_CTRL, (1 << CTRL_CHAOS_A) | (1 << CTRL_CHAOS_B));
        random_traffic(300);
        assert (chaos_hits_a > 0 && chaos_hits_b > 0) else
            report_failure("chaos mode never dropped ready on a fifo with room");
        apb_access(1'b1, REG_CTRL, '0);
        drain(1'b1);

        // park words in both fifos for the clear to drop
        repeat (3)
            drive(1'b1, 1'b1, 1'b0);
        drive(1'b0, 1'b0, 1'b0);
        apb_access(1'b1, REG_CTRL, 1 << CTRL_CLEAR);
        drain(1'b0);
        apb_access(1'b0, REG_STATUS, '0);
        check_reg("STATUS", (1 << STAT_EMPTY_A) | (1 << STAT_EMPTY_B), rd_data);
        apb_access(1'b0, REG_CNT_A, '0);
        check_reg("CNT_A", 0, rd_data);
        apb_access(1'b0, REG_CNT_B, '0);
        check_reg("CNT_B", 0, rd_data);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: flist.f
hw/merge_pkg.sv
hw/sync_fifo.sv
hw/rr_merge.sv
hw/apb_regs.sv
hw/merge_top.sv
verification/tb_merge_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the stream merger testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_merge_top -Mdir obj_dir -o sim_merge -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed (status $status)"
    exit $status
fi

./obj_dir/sim_merge
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed (status $status)"
    exit $status
fi
exit 0
